//--- src/retro_io_pkg.sv
`default_nettype none

package retro_io_pkg;

  // Widths with a meaning
  typedef logic [15:0] io_addr_t;     // Full port address
  typedef logic [7:0]  io_data_t;     // Data byte
  typedef logic [7:0]  zx_reg_t;      // Extension register number
  typedef logic [7:0]  audio_level_t; // Mixer level
  typedef logic [4:0]  joy_t;         // Right, left, down, up, fire

  ////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////
  typedef struct packed {
    logic     psel;
    logic     penable;
    logic     pwrite;
    io_addr_t paddr;
    io_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    io_data_t prdata;
    logic     pready;
  } apb_rsp_t;

  // One I/O cycle, valid for the whole access phase
  typedef struct packed {
    logic     valid;
    logic     write;
    io_addr_t addr;
    io_data_t wdata;
  } io_req_t;

  typedef struct packed {
    logic     hit;   // Address decoded here
    logic     ready; // Cycle completes
    io_data_t rdata;
  } io_rsp_t;

  // Extension register access
  typedef struct packed {
    logic     valid;
    logic     write;
    zx_reg_t  reg_num;
    io_data_t wdata;
  } reg_req_t;

  ////////////////////////////////////////
  // Ports and registers
  ////////////////////////////////////////
  localparam io_addr_t PORT_REG_ADDR    = 16'hFC3B;
  localparam io_addr_t PORT_REG_DATA    = 16'hFD3B;
  localparam logic [7:0] PORT_KEMPSTON_LO = 8'h1F; // Low byte only
  localparam zx_reg_t  REG_FLASH_DATA   = 8'h02;
  localparam zx_reg_t  REG_FLASH_CS     = 8'h03;

  // SPI clock derived from clk
  localparam int SPI_HALF_PERIOD = 2;
  localparam int SPI_HALF_W      = $clog2(SPI_HALF_PERIOD);

  // Mixer weights
  localparam audio_level_t LEVEL_SPK = 8'd128;
  localparam audio_level_t LEVEL_EAR = 8'd64;
  localparam audio_level_t LEVEL_MIC = 8'd32;

  localparam io_data_t UNMAPPED_DATA = 8'hFF; // Floating bus

endpackage

`default_nettype wire

//--- src/apb_io_bridge.sv
`timescale 1ns/1ns
`default_nettype none

// APB to I/O cycle bridge with the Kempston port and the read-data priority mux
module apb_io_bridge
  import retro_io_pkg::*;
(
  input  wire      clk,
  input  wire      reset,
  input  wire      apb_req_t apb_in,
  input  wire      joy_t     joy,
  input  wire      io_rsp_t  regs_rsp,
  input  wire      io_rsp_t  mixer_rsp,
  output apb_rsp_t apb_out,
  output io_req_t  io_req
);

  joy_t    joy_q;     // Registered buttons
  logic    kemp_hit;
  io_rsp_t kemp_rsp;

  ////////////////////////////////////////
  // I/O cycle from the access phase
  ////////////////////////////////////////
  // Setup phase is ignored, the cycle only exists while penable is high
  always_comb begin
    io_req.valid = apb_in.psel && apb_in.penable;
    io_req.write = apb_in.pwrite;
    io_req.addr  = apb_in.paddr;
    io_req.wdata = apb_in.pwdata;
  end

  ////////////////////////////////////////
  // Kempston joystick
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      joy_q <= '0;
    end else begin
      joy_q <= joy; // One stage, buttons are asynchronous
    end
  end

  // Only the low address byte is decoded, as on the real machine
  assign kemp_hit = io_req.valid && !io_req.write &&
                    (io_req.addr[7:0] == PORT_KEMPSTON_LO);

  always_comb begin
    kemp_rsp.hit   = kemp_hit;
    kemp_rsp.ready = 1'b1;               // Never waits
    kemp_rsp.rdata = {3'b000, joy_q};    // Upper bits read as zero
  end

  ////////////////////////////////////////
  // Response priority mux
  ////////////////////////////////////////
  // Order: extension registers, Kempston, mixer, then floating bus
  always_comb begin
    if (regs_rsp.hit) begin
      apb_out.prdata = regs_rsp.rdata;
      apb_out.pready = regs_rsp.ready;   // May stall on a flash transfer
    end else if (kemp_rsp.hit) begin
      apb_out.prdata = kemp_rsp.rdata;
      apb_out.pready = kemp_rsp.ready;
    end else if (mixer_rsp.hit) begin
      apb_out.prdata = mixer_rsp.rdata;
      apb_out.pready = mixer_rsp.ready;
    end else begin
      // Nobody claims the port
      apb_out.prdata = UNMAPPED_DATA;
      apb_out.pready = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/zxuno_regs.sv
`timescale 1ns/1ns
`default_nettype none

// ZX-Uno extension register address/data port pair
module zxuno_regs
  import retro_io_pkg::*;
(
  input  wire      clk,
  input  wire      reset,
  input  wire      io_req_t io_req,
  input  wire      io_rsp_t flash_rsp,
  output io_rsp_t  io_rsp,
  output reg_req_t reg_req
);

  zx_reg_t reg_addr;  // Currently selected register
  logic    hit_addr;  // Access to 0xFC3B
  logic    hit_data;  // Access to 0xFD3B

  assign hit_addr = io_req.valid && (io_req.addr == PORT_REG_ADDR);
  assign hit_data = io_req.valid && (io_req.addr == PORT_REG_DATA);

  // Address port is zero-wait, latched when the cycle completes
  always_ff @(posedge clk) begin
    if (reset) begin
      reg_addr <= '0;
    end else if (hit_addr && io_req.write) begin
      reg_addr <= io_req.wdata;
    end
  end

  ////////////////////////////////////////
  // Data port forwarding
  ////////////////////////////////////////
  always_comb begin
    reg_req.valid   = hit_data;
    reg_req.write   = io_req.write;
    reg_req.reg_num = reg_addr;      // Selected register
    reg_req.wdata   = io_req.wdata;
  end

  always_comb begin
    io_rsp.hit = hit_addr || hit_data;
    if (hit_addr) begin
      io_rsp.ready = 1'b1;
      io_rsp.rdata = reg_addr;       // Readback of the address
    end else if (flash_rsp.hit) begin
      io_rsp.ready = flash_rsp.ready; // Stalls while SPI busy
      io_rsp.rdata = flash_rsp.rdata;
    end else begin
      // Unimplemented register
      io_rsp.ready = 1'b1;
      io_rsp.rdata = UNMAPPED_DATA;
    end
  end

endmodule

`default_nettype wire

//--- src/flash_spi.sv
`timescale 1ns/1ns
`default_nettype none

// SPI mode 0 byte master for the boot flash, registers 0x02 and 0x03
module flash_spi
  import retro_io_pkg::*;
(
  input  wire     clk,
  input  wire     reset,
  input  wire     reg_req_t reg_req,
  input  wire     flash_do,
  output io_rsp_t reg_rsp,
  output logic    flash_cs_n,
  output logic    flash_clk,
  output logic    flash_di
);

  typedef enum logic {ST_IDLE, ST_SHIFT} spi_state_t;

  spi_state_t            state;
  io_data_t              shreg;     // Out on MSB, in at LSB
  io_data_t              rx_buf;    // Last received byte
  logic [2:0]            bit_cnt;
  logic [SPI_HALF_W-1:0] half_cnt;
  logic                  sclk;
  logic                  din_q;     // flash_do taken at the rise
  logic                  cs_q;
  logic                  busy;
  logic                  hit_data, hit_cs, start, half_end;

  assign busy     = (state == ST_SHIFT);
  assign hit_data = reg_req.valid && (reg_req.reg_num == REG_FLASH_DATA);
  assign hit_cs   = reg_req.valid && (reg_req.reg_num == REG_FLASH_CS);
  assign start    = hit_data && reg_req.write && !busy; // Write completes here
  assign half_end = (half_cnt == SPI_HALF_W'(SPI_HALF_PERIOD - 1));

  ////////////////////////////////////////
  // Control FSM and clock generation
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      half_cnt <= '0;
      sclk     <= 1'b0;
      cs_q     <= 1'b1; // Deselected
    end else begin
      if (hit_cs && reg_req.write) cs_q <= reg_req.wdata[0];
      case (state)
        ST_IDLE: begin
          if (start) begin
            state    <= ST_SHIFT;
            bit_cnt  <= '0;
            half_cnt <= '0;
            sclk     <= 1'b0;
          end
        end
        ST_SHIFT: begin
          half_cnt <= half_end ? '0 : half_cnt + 1'b1;
          if (half_end) begin
            sclk <= ~sclk;            // Low half then high half
            if (sclk) begin           // Falling edge ends the bit
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 3'd7) state <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Data path, shift on the fall so MOSI is stable across the rise
  always_ff @(posedge clk) begin
    if (start) begin
      shreg <= reg_req.wdata;
    end else if (busy && half_end) begin
      if (!sclk) begin
        din_q <= flash_do;                     // Sample on the rise
      end else begin
        shreg <= {shreg[6:0], din_q};
        if (bit_cnt == 3'd7) rx_buf <= {shreg[6:0], din_q};
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////
  assign flash_clk  = sclk;
  assign flash_cs_n = cs_q;
  assign flash_di   = busy && shreg[7]; // Quiet low between transfers

  always_comb begin
    reg_rsp.hit   = hit_data || hit_cs;
    reg_rsp.ready = !(hit_data && busy);  // Data register waits out a transfer
    reg_rsp.rdata = hit_cs ? {7'h7F, cs_q} : rx_buf;
  end

endmodule

`default_nettype wire

//--- src/audio_mixer.sv
`timescale 1ns/1ns
`default_nettype none

// Port 0xFE beeper and mic latch with a first-order sigma-delta DAC
module audio_mixer
  import retro_io_pkg::*;
(
  input  wire     clk,
  input  wire     reset,
  input  wire     io_req_t io_req,
  input  wire     ear,
  output io_rsp_t io_rsp,
  output logic    audio_out
);

  logic         hit;
  logic         spk;        // Port bit 4
  logic         mic;        // Port bit 3
  audio_level_t level_sum;  // Weighted sources
  audio_level_t level;      // Registered DAC input
  audio_level_t acc;

  // ULA decodes A0 only, so every even port lands here
  assign hit = io_req.valid && !io_req.addr[0];

  always_comb begin
    io_rsp.hit   = hit;
    io_rsp.ready = 1'b1;
    io_rsp.rdata = {1'b1, ear, 6'h3F}; // EAR on bit 6, rest high
  end

  ////////////////////////////////////////
  // Source weighting
  ////////////////////////////////////////
  // Weights are powers of two and never overflow 8 bits
  always_comb begin
    level_sum = '0;
    if (spk) level_sum = level_sum + LEVEL_SPK;
    if (ear) level_sum = level_sum + LEVEL_EAR;
    if (mic) level_sum = level_sum + LEVEL_MIC;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      spk <= 1'b0;
      mic <= 1'b0;
    end else if (hit && io_req.write) begin
      spk <= io_req.wdata[4];
      mic <= io_req.wdata[3];
    end
  end

  ////////////////////////////////////////
  // Sigma-delta DAC
  ////////////////////////////////////////
  // Carry out of the accumulator is the bitstream, density level/256
  always_ff @(posedge clk) begin
    if (reset) begin
      level     <= '0;
      acc       <= '0;
      audio_out <= 1'b0;
    end else begin
      level            <= level_sum; // One cycle behind the latch
      {audio_out, acc} <= {1'b0, acc} + {1'b0, level};
    end
  end

endmodule

`default_nettype wire

//--- src/io_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

// I/O side of the machine: APB bridge, extension registers, flash SPI, audio
module io_subsystem
  import retro_io_pkg::*;
(
  input  wire      clk,
  input  wire      reset,
  input  wire      apb_req_t apb_in,
  input  wire      joy_t     joy,
  input  wire      ear,        // Tape input
  input  wire      flash_do,
  output apb_rsp_t apb_out,
  output logic     flash_cs_n,
  output logic     flash_clk,
  output logic     flash_di,
  output logic     audio_out   // 1-bit DAC stream
);

  io_req_t  io_req;     // Shared I/O cycle
  io_rsp_t  regs_rsp;
  io_rsp_t  mixer_rsp;
  reg_req_t reg_req;    // Data-port access to a register
  io_rsp_t  flash_rsp;

  ////////////////////////////////////////
  // Host bridge
  ////////////////////////////////////////
  apb_io_bridge u_bridge (
    .clk       (clk),
    .reset     (reset),
    .apb_in    (apb_in),
    .joy       (joy),
    .regs_rsp  (regs_rsp),
    .mixer_rsp (mixer_rsp),
    .apb_out   (apb_out),
    .io_req    (io_req)
  );

  ////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////
  zxuno_regs u_regs (
    .clk       (clk),
    .reset     (reset),
    .io_req    (io_req),
    .flash_rsp (flash_rsp),
    .io_rsp    (regs_rsp),
    .reg_req   (reg_req)
  );

  // Sits behind registers 0x02 and 0x03
  flash_spi u_flash (
    .clk        (clk),
    .reset      (reset),
    .reg_req    (reg_req),
    .flash_do   (flash_do),
    .reg_rsp    (flash_rsp),
    .flash_cs_n (flash_cs_n),
    .flash_clk  (flash_clk),
    .flash_di   (flash_di)
  );

  audio_mixer u_mixer (
    .clk       (clk),
    .reset     (reset),
    .io_req    (io_req),
    .ear       (ear),
    .io_rsp    (mixer_rsp),
    .audio_out (audio_out)
  );

endmodule

`default_nettype wire

//--- test/io_subsystem_sva.sv
`timescale 1ns/1ns
`default_nettype none

// Checks on the flash SPI master, bound into flash_spi
module flash_spi_sva (
  input wire clk,
  input wire reset,
  input wire busy,
  input wire flash_clk,
  input wire flash_cs_n
);

  logic [5:0] busy_run;  // Cycles spent in the current transfer

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_run <= '0;
    end else begin
      busy_run <= busy ? busy_run + 1'b1 : '0;
    end
  end

  ////////////////////////////////////////
  // SPI clock parks low between transfers
  clk_idle_low: assert property (@(posedge clk) disable iff (reset) !busy |-> !flash_clk)
    else $error("flash_clk high while the SPI master is idle");

  // Flash deselected as soon as reset lets go
  cs_after_reset: assert property (@(posedge clk) $fell(reset) |-> flash_cs_n)
    else $error("flash_cs_n low in the first cycle after reset");

  // One byte is 8 bits of 4 clk cycles
  busy_not_long: assert property (@(posedge clk) disable iff (reset) busy |-> busy_run < 6'd32)
    else $error("SPI transfer longer than 32 cycles");
  busy_exact: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> busy_run == 6'd32)
    else $error("SPI transfer ended before 32 cycles");

endmodule

bind flash_spi flash_spi_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .busy       (busy),
  .flash_clk  (flash_clk),
  .flash_cs_n (flash_cs_n)
);

`default_nettype wire

//--- test/io_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module io_subsystem_tb
  import retro_io_pkg::*;
();

  logic     clk;
  logic     reset;
  apb_req_t apb_in;
  apb_rsp_t apb_out;
  joy_t     joy;
  logic     ear;
  logic     flash_do;   // From the flash model
  logic     flash_cs_n;
  logic     flash_clk;
  logic     flash_di;
  logic     audio_out;
  int       seed;       // For the padding joystick values

  io_subsystem uut (
    .clk        (clk),
    .reset      (reset),
    .apb_in     (apb_in),
    .joy        (joy),
    .ear        (ear),
    .flash_do   (flash_do),
    .apb_out    (apb_out),
    .flash_cs_n (flash_cs_n),
    .flash_clk  (flash_clk),
    .flash_di   (flash_di),
    .audio_out  (audio_out)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  ////////////////////////////////////////
  // Failure and compare tasks
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input io_data_t expected, input io_data_t actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %02h actual %02h", name, expected, actual));
  endtask

  task automatic check_level(input string name, input audio_level_t expected,
                             input audio_level_t actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("Error: %s expected %b actual %b", name, expected, actual));
  endtask

  ////////////////////////////////////////
  // APB host
  task automatic apb_transfer(input string name, input logic write, input io_addr_t addr,
                              input io_data_t wdata, output io_data_t rdata, output int stall);
    int cnt;
    @(posedge clk);
    apb_in.psel    <= 1'b1;  // Setup phase
    apb_in.penable <= 1'b0;
    apb_in.pwrite  <= write;
    apb_in.paddr   <= addr;
    apb_in.pwdata  <= wdata;
    @(posedge clk);
    apb_in.penable <= 1'b1;  // Access phase
    cnt = 0;
    @(negedge clk);
    while (apb_out.pready !== 1'b1) begin
      cnt++;
      if (cnt > 100) abort_run($sformatf("Timeout waiting for pready in %s", name));
      @(negedge clk);
    end
    rdata = apb_out.prdata;
    stall = cnt;             // Access-phase cycles with pready low
    @(posedge clk);          // Completing edge
    apb_in <= '0;
  endtask

  task automatic apb_write(input string name, input io_addr_t addr, input io_data_t wdata);
    io_data_t ignored_rdata;
    int       ignored_stall;
    apb_transfer(name, 1'b1, addr, wdata, ignored_rdata, ignored_stall);
  endtask

  task automatic apb_read(input string name, input io_addr_t addr,
                          output io_data_t rdata, output int stall);
    apb_transfer(name, 1'b0, addr, 8'h00, rdata, stall);
  endtask

  ////////////////////////////////////////
  // SPI flash slave, mode 0
  task automatic flash_slave(input string name, input io_data_t reply, output io_data_t mosi);
    io_data_t shift;  // Next reply bit sits in bit 7
    logic     prev;
    logic     cur;
    int       falls;
    int       cnt;
    shift = reply;
    mosi  = '0;
    falls = 0;
    cnt   = 0;
    prev  = flash_clk;
    while (falls < 8) begin
      @(negedge clk);
      cnt++;
      if (cnt > 200) abort_run($sformatf("Timeout waiting for flash_clk edges in %s", name));
      cur = flash_clk;
      if (cur && !prev) mosi = {mosi[6:0], flash_di};  // Capture on the rise
      if (!cur && prev) begin
        falls++;
        shift = {shift[6:0], 1'b0};
        @(posedge clk);
        flash_do <= shift[7];  // Next reply bit after the fall
      end
      prev = cur;
    end
  endtask

  ////////////////////////////////////////
  // Case steps
  task automatic spi_step(input string name, input io_addr_t addr, input io_data_t wdata,
                          input io_data_t exp_mosi, input io_data_t reply);
    io_data_t mosi;
    io_data_t rdata;
    int       stall;
    @(posedge clk);
    flash_do <= reply[7];  // First bit ahead of the first rise
    fork
      flash_slave(name, reply, mosi);
      begin
        apb_write(name, addr, wdata);
        apb_read(name, addr, rdata, stall);  // Issued while the transfer runs
      end
    join
    check_data({name, " mosi"}, exp_mosi, mosi);
    check_bit({name, " stall"}, 1'b1, stall > 0);
    check_data({name, " reply"}, reply, rdata);
  endtask

  // Ones in 256 cycles counted from 2 cycles after the setting
  task automatic audio_count(input string name, input audio_level_t expected);
    int ones;
    ones = 0;
    repeat (2) @(posedge clk);  // Level register, then accumulator
    repeat (256) begin
      @(negedge clk);
      if (audio_out) ones++;
    end
    if (ones > 255) abort_run($sformatf("Audio output stuck high in %s", name));
    check_level(name, expected, audio_level_t'(ones));
  endtask

  ////////////////////////////////////////
  // Main sequence
  initial begin
    int       fd;
    int       got;
    int       line_no;
    int       fields;
    int       stall;
    string    line;
    string    name;
    byte      kind;
    io_addr_t addr;
    io_data_t data;
    io_data_t expected;
    io_data_t reply;
    io_data_t rdata;
    joy_t     joy_val;
    reset    <= 1'b1;
    apb_in   <= '0;
    joy      <= '0;
    ear      <= 1'b0;
    flash_do <= 1'b0;
    seed = 23;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    fd = $fopen("test/io_cases.txt", "r");
    if (fd == 0) abort_run("Cannot open test/io_cases.txt");
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      line_no++;
      if (got == 0 || line.len() < 2 || line[0] == "#") continue;
      fields = $sscanf(line, "%c %h %h %h %h", kind, addr, data, expected, reply);
      if (fields != 5) abort_run($sformatf("Malformed case on line %0d", line_no));
      name = $sformatf("line %0d %c", line_no, kind);
      case (kind)
        "W": apb_write(name, addr, data);
        "R": begin
          apb_read(name, addr, rdata, stall);
          check_data(name, expected, rdata);
        end
        "J": begin
          @(posedge clk);
          joy <= joy_t'(data);
        end
        "E": begin
          @(posedge clk);
          ear <= data[0];
        end
        "C": begin
          @(negedge clk);
          check_bit(name, expected[0], flash_cs_n);  // Chip select pin
        end
        "S": spi_step(name, addr, data, expected, reply);
        "A": audio_count(name, audio_level_t'(expected));
        default: abort_run($sformatf("Unknown case kind on line %0d", line_no));
      endcase
    end
    $fclose(fd);

    // Padding Kempston reads with random buttons under three zero bits
    repeat (4) begin
      joy_val = joy_t'($random(seed));
      @(posedge clk);
      joy <= joy_val;
      apb_read("kempston random", {8'h00, PORT_KEMPSTON_LO}, rdata, stall);
      check_data("kempston random", {3'b000, joy_val}, rdata);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/retro_io_pkg.sv
src/apb_io_bridge.sv
src/zxuno_regs.sv
src/flash_spi.sv
src/audio_mixer.sv
src/io_subsystem.sv
test/io_subsystem_sva.sv
test/io_subsystem_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the io_subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module io_subsystem_tb \
  -f project.f \
  -o io_subsystem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/io_subsystem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit $status
fi
exit 0

//--- test/io_cases.txt
# kind addr data expected reply (hex), unused fields are 0
# W write, R read, J joy, E ear, C cs_n pin, S SPI write, A audio ones in 256 cycles
C 0000 00 01 00
A 0000 00 00 00
R FC3B 00 00 00
W FC3B 7E 00 00
R FC3B 00 7E 00
R FD3B 00 FF 00
W FC3B 03 00 00
W FD3B 00 00 00
R FD3B 00 FE 00
C 0000 00 00 00
W FC3B 02 00 00
S FD3B A5 A5 3C
R FD3B 00 3C 00
W FC3B 03 00 00
W FD3B 01 00 00
C 0000 00 01 00
J 0000 15 00 00
R 001F 00 15 00
R 0033 00 FF 00
E 0000 01 00 00
R 00FE 00 FF 00
W 00FE 18 00 00
A 0000 00 E0 00
E 0000 00 00 00
R 00FE 00 BF 00
A 0000 00 A0 00
W 00FE 10 00 00
A 0000 00 80 00
